// File: source/insn_pkg.sv
// ======================================
// shared definitions for the instruction-length front end
// opcode encodings, assembler states, the instruction record
// and the sizing constants for both credit interfaces
// ======================================
package insn_pkg;

	// ======================================
	// sizing
	// ======================================

	// ingress depth, which is also the number of credits the byte source starts with
	localparam int BYTE_FIFO_DEPTH = 8;
	// records the consumer can take before it has to return credits
	localparam int INSN_CREDITS = 4;
	// address of the first byte after reset
	localparam logic [15:0] RESET_PC = 16'hE000;

	// pointer and occupancy widths follow from the two depths
	localparam int BYTE_PTR_W = $clog2(BYTE_FIFO_DEPTH);
	localparam int BYTE_CNT_W = $clog2(BYTE_FIFO_DEPTH + 1);
	localparam int INSN_CNT_W = $clog2(INSN_CREDITS + 1);

	// ======================================
	// opcodes, real 65816 encodings
	// ======================================
	typedef enum logic [7:0] {
		// implied, flag, transfer and inc/dec forms
		op_clc = 8'h18, op_sec = 8'h38, op_cli = 8'h58, op_sei = 8'h78,
		op_clv = 8'hb8, op_cld = 8'hd8, op_sed = 8'hf8, op_nop = 8'hea,
		op_tax = 8'haa, op_txa = 8'h8a, op_tay = 8'ha8, op_tya = 8'h98,
		op_tsx = 8'hba, op_txs = 8'h9a, op_txy = 8'h9b, op_tyx = 8'hbb,
		op_xba = 8'heb, op_xce = 8'hfb, op_stp = 8'hdb, op_wai = 8'hcb,
		op_inx = 8'he8, op_dex = 8'hca, op_iny = 8'hc8, op_dey = 8'h88,
		op_ina = 8'h1a, op_dea = 8'h3a, op_rts = 8'h60, op_rtl = 8'h6b,
		op_rti = 8'h40, op_asl_acc = 8'h0a, op_rol_acc = 8'h2a, op_lsr_acc = 8'h4a,
		op_ror_acc = 8'h6a,
		// pushes and pulls, including the effective address pushes
		op_php = 8'h08, op_pha = 8'h48, op_phx = 8'hda, op_phy = 8'h5a,
		op_plp = 8'h28, op_pla = 8'h68, op_plx = 8'hfa, op_ply = 8'h7a,
		op_phb = 8'h8b, op_phd = 8'h0b, op_phk = 8'h4b, op_plb = 8'hab,
		op_pld = 8'h2b, op_pea = 8'hf4, op_per = 8'h62, op_pei = 8'hd4,
		// mode changes, interrupts, branches and jumps
		op_brk = 8'h00, op_sep = 8'he2, op_rep = 8'hc2, op_brl = 8'h82,
		op_bpl = 8'h10, op_bmi = 8'h30, op_bvc = 8'h50, op_bvs = 8'h70,
		op_bra = 8'h80, op_bcc = 8'h90, op_bcs = 8'hb0, op_bne = 8'hd0,
		op_beq = 8'hf0, op_jmp = 8'h4c, op_jmp_ind = 8'h6c, op_jmp_indx = 8'h7c,
		op_jsr = 8'h20, op_jsr_indx = 8'hfc, op_jml = 8'h5c, op_jsl = 8'h22,
		// immediates, the accumulator group first and then the index group
		op_ora_imm = 8'h09, op_and_imm = 8'h29, op_eor_imm = 8'h49, op_adc_imm = 8'h69,
		op_bit_imm = 8'h89, op_lda_imm = 8'ha9, op_cmp_imm = 8'hc9, op_sbc_imm = 8'he9,
		op_ldy_imm = 8'ha0, op_ldx_imm = 8'ha2, op_cpy_imm = 8'hc0, op_cpx_imm = 8'he0,
		// direct page and direct page indexed
		op_ora_zp = 8'h05, op_and_zp = 8'h25, op_eor_zp = 8'h45, op_adc_zp = 8'h65,
		op_sta_zp = 8'h85, op_lda_zp = 8'ha5, op_cmp_zp = 8'hc5, op_sbc_zp = 8'he5,
		op_ldx_zp = 8'ha6, op_ldy_zp = 8'ha4, op_stx_zp = 8'h86, op_sty_zp = 8'h84,
		op_stz_zp = 8'h64, op_bit_zp = 8'h24, op_inc_zp = 8'he6, op_dec_zp = 8'hc6,
		op_ora_zpx = 8'h15, op_and_zpx = 8'h35, op_eor_zpx = 8'h55, op_adc_zpx = 8'h75,
		op_sta_zpx = 8'h95, op_lda_zpx = 8'hb5, op_cmp_zpx = 8'hd5, op_sbc_zpx = 8'hf5,
		op_ldy_zpx = 8'hb4, op_sty_zpx = 8'h94, op_ldx_zpy = 8'hb6, op_stx_zpy = 8'h96,
		// indirect forms and stack relative
		op_ora_indy = 8'h11, op_and_indy = 8'h31, op_eor_indy = 8'h51, op_adc_indy = 8'h71,
		op_sta_indy = 8'h91, op_lda_indy = 8'hb1, op_cmp_indy = 8'hd1, op_sbc_indy = 8'hf1,
		op_lda_ind = 8'hb2, op_sta_ind = 8'h92, op_lda_indx = 8'ha1, op_sta_indx = 8'h81,
		op_lda_indl = 8'ha7, op_sta_indl = 8'h87, op_lda_indly = 8'hb7, op_sta_indly = 8'h97,
		op_lda_sr = 8'ha3, op_sta_sr = 8'h83, op_adc_sr = 8'h63, op_cmp_sr = 8'hc3,
		op_lda_sry = 8'hb3, op_sta_sry = 8'h93,
		// absolute and absolute indexed
		op_ora_abs = 8'h0d, op_and_abs = 8'h2d, op_eor_abs = 8'h4d, op_adc_abs = 8'h6d,
		op_sta_abs = 8'h8d, op_lda_abs = 8'had, op_cmp_abs = 8'hcd, op_sbc_abs = 8'hed,
		op_ldx_abs = 8'hae, op_ldy_abs = 8'hac, op_stx_abs = 8'h8e, op_sty_abs = 8'h8c,
		op_stz_abs = 8'h9c, op_bit_abs = 8'h2c, op_inc_abs = 8'hee, op_dec_abs = 8'hce,
		op_ora_absx = 8'h1d, op_and_absx = 8'h3d, op_eor_absx = 8'h5d, op_adc_absx = 8'h7d,
		op_sta_absx = 8'h9d, op_lda_absx = 8'hbd, op_cmp_absx = 8'hdd, op_sbc_absx = 8'hfd,
		op_ldy_absx = 8'hbc, op_ldx_absy = 8'hbe, op_lda_absy = 8'hb9, op_sta_absy = 8'h99,
		// absolute long and long indexed
		op_ora_long = 8'h0f, op_and_long = 8'h2f, op_eor_long = 8'h4f, op_adc_long = 8'h6f,
		op_sta_long = 8'h8f, op_lda_long = 8'haf, op_cmp_long = 8'hcf, op_sbc_long = 8'hef,
		op_lda_longx = 8'hbf, op_sta_longx = 8'h9f
	} opcode_e;

	// assembler FSM
	typedef enum logic [1:0] {
		idle_opcode,
		collect_operand,
		hold_output
	} asm_state_e;

	// one assembled instruction, operand byte 1 sits in the low bits
	typedef struct packed {
		logic [15:0] pc;
		logic [7:0]  opcode;
		logic [23:0] operand;
		logic [2:0]  length;
		logic        illegal;
		logic        m_bit;
		logic        x_bit;
	} insn_t;

endpackage

// File: source/byte_ingress.sv
// ======================================
// byte_ingress
// byte FIFO on the upstream credit interface, returns one
// credit pulse for every byte the assembler pops
// ======================================
`timescale 1ns/10ps

module byte_ingress import insn_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       byte_valid,
	input  logic [7:0] byte_data,
	input  logic       head_pop,
	output logic       head_valid,
	output logic [7:0] head_data,
	output logic       byte_credit
);

	logic [7:0]            mem [BYTE_FIFO_DEPTH];
	logic [BYTE_PTR_W-1:0] wr_ptr;
	logic [BYTE_PTR_W-1:0] rd_ptr;
	logic [BYTE_CNT_W-1:0] count;
	logic                  push;
	logic                  pop;

	// the source only sends while it holds a credit, so a valid byte always has room
	assign push = byte_valid;
	// a pop request against an empty FIFO is ignored
	assign pop = head_pop && head_valid;

	assign head_valid = (count != '0);
	// head is read straight out of the array, no output register
	assign head_data = mem[rd_ptr];

	// storage array, payload only
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= byte_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			byte_credit <= 1'b0;
		end else begin
			// both pointers wrap at the last entry
			if (push) begin
				wr_ptr <= (wr_ptr == BYTE_PTR_W'(BYTE_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == BYTE_PTR_W'(BYTE_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy holds when a push and a pop land together
			count <= count + BYTE_CNT_W'(push) - BYTE_CNT_W'(pop);
			// every freed entry goes back upstream one cycle later
			byte_credit <= pop;
		end
	end

endmodule

// File: source/insn_length_decode.sv
// ======================================
// insn_length_decode
// opcode to instruction length table, 1 to 4 bytes,
// immediates sized by m_bit and x_bit, unknown opcodes flagged
// ======================================
`timescale 1ns/10ps

module insn_length_decode import insn_pkg::*; (
	input  logic [7:0] opcode,
	input  logic       m_bit,
	input  logic       x_bit,
	output logic [2:0] length,
	output logic       illegal
);

	opcode_e op;

	assign op = opcode_e'(opcode);

	always_comb begin
		illegal = 1'b0;
		case (op)
			// single byte forms, no operand at all
			op_clc, op_sec, op_cli, op_sei, op_clv, op_cld, op_sed, op_nop,
			op_tax, op_txa, op_tay, op_tya, op_tsx, op_txs, op_txy, op_tyx,
			op_xba, op_xce, op_stp, op_wai, op_rts, op_rtl, op_rti,
			op_inx, op_dex, op_iny, op_dey, op_ina, op_dea,
			op_asl_acc, op_rol_acc, op_lsr_acc, op_ror_acc,
			op_php, op_pha, op_phx, op_phy, op_plp, op_pla, op_plx, op_ply,
			op_phb, op_phd, op_phk, op_plb, op_pld:
				length = 3'd1;

			// one operand byte
			// BRK carries its signature byte, branches an 8-bit displacement
			op_brk, op_sep, op_rep, op_pei,
			op_bpl, op_bmi, op_bvc, op_bvs, op_bra, op_bcc, op_bcs, op_bne, op_beq,
			op_ora_zp, op_and_zp, op_eor_zp, op_adc_zp, op_sta_zp, op_lda_zp,
			op_cmp_zp, op_sbc_zp, op_ldx_zp, op_ldy_zp, op_stx_zp, op_sty_zp,
			op_stz_zp, op_bit_zp, op_inc_zp, op_dec_zp,
			op_ora_zpx, op_and_zpx, op_eor_zpx, op_adc_zpx, op_sta_zpx, op_lda_zpx,
			op_cmp_zpx, op_sbc_zpx, op_ldy_zpx, op_sty_zpx, op_ldx_zpy, op_stx_zpy,
			op_ora_indy, op_and_indy, op_eor_indy, op_adc_indy, op_sta_indy,
			op_lda_indy, op_cmp_indy, op_sbc_indy, op_lda_ind, op_sta_ind,
			op_lda_indx, op_sta_indx, op_lda_indl, op_sta_indl, op_lda_indly,
			op_sta_indly, op_lda_sr, op_sta_sr, op_adc_sr, op_cmp_sr,
			op_lda_sry, op_sta_sry:
				length = 3'd2;

			// 16-bit address or displacement
			op_jmp, op_jmp_ind, op_jmp_indx, op_jsr, op_jsr_indx,
			op_pea, op_per, op_brl,
			op_ora_abs, op_and_abs, op_eor_abs, op_adc_abs, op_sta_abs, op_lda_abs,
			op_cmp_abs, op_sbc_abs, op_ldx_abs, op_ldy_abs, op_stx_abs, op_sty_abs,
			op_stz_abs, op_bit_abs, op_inc_abs, op_dec_abs,
			op_ora_absx, op_and_absx, op_eor_absx, op_adc_absx, op_sta_absx,
			op_lda_absx, op_cmp_absx, op_sbc_absx, op_ldy_absx, op_ldx_absy,
			op_lda_absy, op_sta_absy:
				length = 3'd3;

			// 24-bit long address
			op_jml, op_jsl,
			op_ora_long, op_and_long, op_eor_long, op_adc_long, op_sta_long,
			op_lda_long, op_cmp_long, op_sbc_long, op_lda_longx, op_sta_longx:
				length = 3'd4;

			// accumulator immediates take a 16-bit operand once m is cleared
			op_ora_imm, op_and_imm, op_eor_imm, op_adc_imm,
			op_bit_imm, op_lda_imm, op_cmp_imm, op_sbc_imm:
				length = m_bit ? 3'd2 : 3'd3;

			// index immediates follow x the same way
			op_ldy_imm, op_ldx_imm, op_cpy_imm, op_cpx_imm:
				length = x_bit ? 3'd2 : 3'd3;

			// unknown opcodes step over one byte so the stream stays aligned
			default: begin
				length  = 3'd1;
				illegal = 1'b1;
			end
		endcase
	end

endmodule

// File: source/insn_assembler.sv
// ======================================
// insn_assembler
// FSM that gathers the opcode and its operand bytes into one
// record, tracks pc and the m/x width flags, applies SEP/REP
// ======================================
`timescale 1ns/10ps

module insn_assembler import insn_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       head_valid,
	input  logic [7:0] head_data,
	output logic       head_pop,
	input  logic [2:0] length,
	input  logic       illegal,
	output logic       m_bit,
	output logic       x_bit,
	output logic [7:0] cur_opcode,
	output logic       rec_valid,
	output insn_t      rec,
	input  logic       rec_ready
);

	asm_state_e  state;
	logic [15:0] pc;
	// index of the next operand byte, 0 to 2
	logic [1:0]  opnd_idx;
	// record under construction, updated on every pop
	insn_t       work;
	logic        last_byte;

	// while idle the decoder looks at the head byte, afterwards at the latched opcode
	assign cur_opcode = (state == idle_opcode) ? head_data : work.opcode;

	// nothing is popped while a finished record waits for egress
	assign head_pop = head_valid && (state != hold_output);

	// the record goes out on the pop of its last byte, or later from hold_output
	assign rec_valid = (state == hold_output) || (head_pop && last_byte);

	// record as it would look with the head byte merged in
	always_comb begin
		rec       = work;
		last_byte = 1'b0;
		case (state)
			idle_opcode: begin
				rec.pc      = pc;
				rec.opcode  = head_data;
				rec.operand = '0;
				rec.length  = length;
				rec.illegal = illegal;
				rec.m_bit   = m_bit;
				rec.x_bit   = x_bit;
				// single byte instructions finish on the opcode itself
				last_byte   = (length == 3'd1);
			end
			collect_operand: begin
				rec.operand[8*opnd_idx +: 8] = head_data;
				// opcode plus this byte plus the ones already taken
				last_byte = ({1'b0, opnd_idx} + 3'd2 == work.length);
			end
			default: begin
				// hold_output shows the stored record unchanged
				last_byte = 1'b0;
			end
		endcase
	end

	// payload register, no reset needed
	always_ff @(posedge clk) begin
		if (head_pop) begin
			work <= rec;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= idle_opcode;
			pc       <= RESET_PC;
			opnd_idx <= '0;
			m_bit    <= 1'b1;
			x_bit    <= 1'b1;
		end else begin
			// the stream is linear, one address per byte
			if (head_pop) begin
				pc <= pc + 16'd1;
				opnd_idx <= (last_byte || state == idle_opcode) ? '0 : opnd_idx + 2'd1;
			end

			if (head_pop && last_byte) begin
				state <= rec_ready ? idle_opcode : hold_output;
			end else if (head_pop) begin
				state <= collect_operand;
			end else if (state == hold_output && rec_ready) begin
				state <= idle_opcode;
			end

			// SEP sets and REP clears m (bit 5) and x (bit 4) as the instruction completes,
			// so the next opcode is already sized with the new widths
			if (head_pop && last_byte && rec.opcode == op_sep) begin
				m_bit <= m_bit | rec.operand[5];
				x_bit <= x_bit | rec.operand[4];
			end
			if (head_pop && last_byte && rec.opcode == op_rep) begin
				m_bit <= m_bit & ~rec.operand[5];
				x_bit <= x_bit & ~rec.operand[4];
			end
		end
	end

endmodule

// File: source/insn_egress.sv
// ======================================
// insn_egress
// one-entry record holding register with a downstream
// credit counter, issues a record only when a credit is held
// ======================================
`timescale 1ns/10ps

module insn_egress import insn_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  rec_valid,
	input  insn_t rec,
	output logic  rec_ready,
	input  logic  insn_credit,
	output logic  insn_valid,
	output insn_t insn
);

	logic                  full;
	logic [INSN_CNT_W-1:0] credits;
	insn_t                 hold;
	logic                  issue;
	logic                  load;

	// a held record leaves as soon as the consumer has room for it
	assign issue = full && (credits != '0);
	// the entry can be refilled in the same cycle it is issued
	assign rec_ready = !full || issue;
	assign load = rec_valid && rec_ready;

	assign insn_valid = issue;
	assign insn = hold;

	always_ff @(posedge clk) begin
		if (load) begin
			hold <= rec;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			full    <= 1'b0;
			credits <= INSN_CNT_W'(INSN_CREDITS);
		end else begin
			if (load) begin
				full <= 1'b1;
			end else if (issue) begin
				full <= 1'b0;
			end
			// an issue and a returned credit in one cycle cancel out
			credits <= credits - INSN_CNT_W'(issue) + INSN_CNT_W'(insn_credit);
		end
	end

endmodule

// File: source/insn_fetch_top.sv
// ======================================
// insn_fetch_top
// byte ingress, length decoder, assembler and record egress
// wired into the instruction-length front end
// ======================================
`timescale 1ns/10ps

module insn_fetch_top import insn_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       byte_valid,
	input  logic [7:0] byte_data,
	output logic       byte_credit,
	output logic       insn_valid,
	output insn_t      insn,
	input  logic       insn_credit
);

	// FIFO head towards the assembler
	logic       head_valid;
	logic [7:0] head_data;
	logic       head_pop;
	// decoder lookup
	logic [7:0] cur_opcode;
	logic       m_bit;
	logic       x_bit;
	logic [2:0] length;
	logic       illegal;
	// finished records towards egress
	logic       rec_valid;
	logic       rec_ready;
	insn_t      rec;

	byte_ingress ingress0 (
		.clk         (clk),
		.reset       (reset),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.head_pop    (head_pop),
		.head_valid  (head_valid),
		.head_data   (head_data),
		.byte_credit (byte_credit)
	);

	insn_length_decode decode0 (
		.opcode  (cur_opcode),
		.m_bit   (m_bit),
		.x_bit   (x_bit),
		.length  (length),
		.illegal (illegal)
	);

	insn_assembler assembler0 (
		.clk        (clk),
		.reset      (reset),
		.head_valid (head_valid),
		.head_data  (head_data),
		.head_pop   (head_pop),
		.length     (length),
		.illegal    (illegal),
		.m_bit      (m_bit),
		.x_bit      (x_bit),
		.cur_opcode (cur_opcode),
		.rec_valid  (rec_valid),
		.rec        (rec),
		.rec_ready  (rec_ready)
	);

	insn_egress egress0 (
		.clk         (clk),
		.reset       (reset),
		.rec_valid   (rec_valid),
		.rec         (rec),
		.rec_ready   (rec_ready),
		.insn_credit (insn_credit),
		.insn_valid  (insn_valid),
		.insn        (insn)
	);

endmodule

// File: verification/insn_fetch_chk.sv
// ======================================
// concurrent checks on both credit interfaces
// models the upstream and downstream credit pools
// and bounds the FIFO occupancy and record length
// bound into insn_fetch_top as chk0
// ======================================
`timescale 1ns/10ps

module insn_fetch_chk import insn_pkg::*; (
	input logic                  clk,
	input logic                  reset,
	input logic                  byte_valid,
	input logic                  byte_credit,
	input logic                  insn_valid,
	input insn_t                 insn,
	input logic                  insn_credit,
	input logic [BYTE_CNT_W-1:0] fifo_count
);

	// credits the byte source holds, and credits egress holds
	int up_cnt;
	int dn_cnt;
	// failed assertions, read by the testbench at the end of the run
	int fails = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			up_cnt <= BYTE_FIFO_DEPTH;
			dn_cnt <= INSN_CREDITS;
		end else begin
			up_cnt <= up_cnt - int'(byte_valid) + int'(byte_credit);
			dn_cnt <= dn_cnt - int'(insn_valid) + int'(insn_credit);
		end
	end

	// a credit pulse in the same cycle is already usable by the source
	up_credit_held: assert property (@(posedge clk) disable iff (reset)
		byte_valid |-> (up_cnt + int'(byte_credit)) > 0)
		else begin
			$error("byte sent while the source held no credit");
			fails++;
		end

	dn_credit_held: assert property (@(posedge clk) disable iff (reset)
		insn_valid |-> dn_cnt > 0)
		else begin
			$error("record issued with no downstream credit");
			fails++;
		end

	fifo_bounded: assert property (@(posedge clk) disable iff (reset)
		fifo_count <= BYTE_CNT_W'(BYTE_FIFO_DEPTH))
		else begin
			$error("byte FIFO occupancy above its depth");
			fails++;
		end

	length_range: assert property (@(posedge clk) disable iff (reset)
		insn_valid |-> (insn.length >= 3'd1 && insn.length <= 3'd4))
		else begin
			$error("record length outside 1 to 4");
			fails++;
		end

endmodule

bind insn_fetch_top insn_fetch_chk chk0 (
	.clk         (clk),
	.reset       (reset),
	.byte_valid  (byte_valid),
	.byte_credit (byte_credit),
	.insn_valid  (insn_valid),
	.insn        (insn),
	.insn_credit (insn_credit),
	.fifo_count  (ingress0.count)
);

// File: verification/insn_fetch_tb.sv
// ======================================
// testbench for the instruction-length front end
// clock, reset, program builder with its own length model,
// byte source and record sink under credit flow control,
// field checks and the closing report
// ======================================
`timescale 1ns/10ps

module insn_fetch_tb import insn_pkg::*;;

	bit          clk;
	logic        reset;
	logic        byte_valid;
	logic [7:0]  byte_data;
	logic        byte_credit;
	logic        insn_valid;
	insn_t       insn;
	logic        insn_credit;

	// program bytes still to send and records still to arrive
	logic [7:0]  byte_q [$];
	insn_t       exp_q [$];
	// credit return delay drawn for each expected record
	int          delay_q [$];
	logic [15:0] model_pc;
	logic        m_model;
	logic        x_model;
	logic        hold_credits;
	int          up_credits;
	int          min_credits;
	int          credit_pulses;
	int          bytes_sent;
	int          total_bytes;
	int          cycles;
	int          owed;
	int          credit_delay;
	int          rx_count;
	int          checks;
	int          errors;

	insn_fetch_top dut0 (
		.clk         (clk),
		.reset       (reset),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.byte_credit (byte_credit),
		.insn_valid  (insn_valid),
		.insn        (insn),
		.insn_credit (insn_credit)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	// ======================================
	// reference length model
	// ======================================

	// 1 to 4 fixed length, 5 accumulator immediate, 6 index immediate, 0 unknown
	function automatic int op_class(input logic [7:0] op);
		case (op)
			8'hea, 8'h18, 8'haa, 8'h48, 8'h6b, 8'h0a, 8'hc8: op_class = 1;
			8'ha5, 8'hb5, 8'hb1, 8'ha3, 8'h80, 8'hd4, 8'h00, 8'he2, 8'hc2: op_class = 2;
			8'had, 8'hbd, 8'h20, 8'hf4, 8'h82, 8'h4c: op_class = 3;
			8'haf, 8'h22, 8'h5c: op_class = 4;
			8'ha9, 8'h69: op_class = 5;
			8'ha2, 8'ha0, 8'hc0: op_class = 6;
			default: op_class = 0;
		endcase
	endfunction

	function automatic logic [23:0] rand_opnd();
		logic [31:0] r;
		r = $urandom();
		return r[23:0];
	endfunction

	// any opcode from the table, SEP and REP included
	function automatic logic [7:0] rand_op();
		logic [31:0] r;
		r = $urandom();
		while (op_class(r[7:0]) == 0) begin
			r = $urandom();
		end
		return r[7:0];
	endfunction

	task automatic add_insn(input logic [7:0] op, input logic [23:0] opnd);
		insn_t r;
		int    cls;
		int    i;
		cls       = op_class(op);
		r.pc      = model_pc;
		r.opcode  = op;
		r.operand = '0;
		r.illegal = (cls == 0);
		r.m_bit   = m_model;
		r.x_bit   = x_model;
		case (cls)
			0: r.length = 3'd1;
			5: r.length = m_model ? 3'd2 : 3'd3;
			6: r.length = x_model ? 3'd2 : 3'd3;
			default: r.length = 3'(cls);
		endcase
		byte_q.push_back(op);
		// operand bytes go out low byte first
		for (i = 1; i < int'(r.length); i++) begin
			r.operand[8*(i-1) +: 8] = opnd[8*(i-1) +: 8];
			byte_q.push_back(opnd[8*(i-1) +: 8]);
		end
		// SEP sets and REP clears m from bit 5 and x from bit 4
		if (op == 8'he2) begin
			m_model = m_model | opnd[5];
			x_model = x_model | opnd[4];
		end
		if (op == 8'hc2) begin
			m_model = m_model & ~opnd[5];
			x_model = x_model & ~opnd[4];
		end
		model_pc = model_pc + 16'(r.length);
		total_bytes += int'(r.length);
		exp_q.push_back(r);
		delay_q.push_back(int'($urandom() % 4));
	endtask

	// opcode in the high byte, the low byte is the operand of SEP and REP only
	task automatic add_list(input logic [15:0] seq [$]);
		foreach (seq[i]) begin
			if (seq[i][15:8] == 8'he2 || seq[i][15:8] == 8'hc2) begin
				add_insn(seq[i][15:8], {16'h0000, seq[i][7:0]});
			end else begin
				add_insn(seq[i][15:8], rand_opnd());
			end
		end
	endtask

	// ======================================
	// checks and reporting
	// ======================================

	task automatic check_field(input string name, input logic [23:0] want, input logic [23:0] got);
		checks++;
		assert (got == want) else begin
			$display("[ERROR] insn.%s expected %h got %h", name, want, got);
			errors++;
		end
	endtask

	task automatic check_record(input insn_t got);
		insn_t want;
		checks++;
		assert (exp_q.size() != 0) else begin
			$display("a record with pc %h arrived when none was pending", got.pc);
			errors++;
		end
		if (exp_q.size() != 0) begin
			want = exp_q.pop_front();
			check_field("pc", want.pc, got.pc);
			check_field("opcode", want.opcode, got.opcode);
			check_field("operand", want.operand, got.operand);
			check_field("length", want.length, got.length);
			check_field("illegal", want.illegal, got.illegal);
			check_field("m_bit", want.m_bit, got.m_bit);
			check_field("x_bit", want.x_bit, got.x_bit);
			rx_count++;
		end
	endtask

	task automatic show_result(input int num, input string name);
		$display("test %0d %s finished, %0d errors so far", num, name, errors);
	endtask

	// all bytes sent, all records seen and all downstream credits returned
	task automatic wait_drain();
		while (byte_q.size() != 0 || exp_q.size() != 0 || owed != 0) begin
			@(posedge clk);
		end
	endtask

	// ======================================
	// byte source, record sink, reset and timeout
	// ======================================
	always @(negedge clk) begin
		cycles++;
		reset = (cycles < 3);
		if (cycles > 20 * total_bytes + 200) begin
			$display("timeout after %0d cycles, the stream never drained", cycles);
			$display("Finished with errors");
			$finish;
		end else if (!reset) begin
			if (byte_credit) begin
				up_credits++;
				credit_pulses++;
			end
			byte_valid = 1'b0;
			if (byte_q.size() != 0 && up_credits != 0) begin
				byte_valid = 1'b1;
				byte_data  = byte_q.pop_front();
				up_credits--;
				bytes_sent++;
			end
			if (up_credits < min_credits) begin
				min_credits = up_credits;
			end
			if (insn_valid) begin
				check_record(insn);
				owed++;
			end
			// each retired record returns its credit after a short random delay
			insn_credit = 1'b0;
			if (credit_delay != 0) begin
				credit_delay--;
			end else if (!hold_credits && owed != 0) begin
				insn_credit = 1'b1;
				owed--;
				if (delay_q.size() != 0) begin
					credit_delay = delay_q.pop_front();
				end
			end
		end
	end

	initial begin
		logic [15:0] seq [$];
		int          start;
		reset        = 1'b1;
		byte_valid   = 1'b0;
		byte_data    = 8'h00;
		insn_credit  = 1'b0;
		hold_credits = 1'b0;
		model_pc     = RESET_PC;
		m_model      = 1'b1;
		x_model      = 1'b1;
		up_credits   = BYTE_FIFO_DEPTH;
		min_credits  = BYTE_FIFO_DEPTH;
		void'($urandom(95065));
		wait (reset == 1'b0);

		// nothing moves while no byte has been sent
		repeat (4) begin
			@(negedge clk);
			checks++;
			assert (!insn_valid && !byte_credit) else begin
				$display("insn_valid or byte_credit went high before any byte was sent");
				errors++;
			end
		end
		show_result(1, "idle after reset");
		@(posedge clk);

		seq = '{16'hea00, 16'ha500, 16'hb100, 16'ha300, 16'h8000, 16'hd400, 16'h0000,
			16'had00, 16'hbd00, 16'h2000, 16'hf400, 16'h8200, 16'haf00, 16'h2200,
			16'h5c00, 16'h4800};
		add_list(seq);
		wait_drain();
		show_result(2, "fixed length classes");

		// SEP #$30, REP #$30, then SEP #$30 with REP #$20
		seq = '{16'he230, 16'ha900, 16'ha200, 16'hc230, 16'ha900, 16'ha200,
			16'he230, 16'hc220, 16'ha900, 16'ha000};
		add_list(seq);
		wait_drain();
		show_result(3, "width flags");

		seq = '{16'h0200, 16'hea00, 16'h4200, 16'ha500, 16'hff00, 16'had00, 16'h0300};
		add_list(seq);
		wait_drain();
		show_result(4, "illegal opcodes");

		hold_credits = 1'b1;
		start = rx_count;
		repeat (10) add_insn(rand_op(), rand_opnd());
		repeat (60) @(posedge clk);
		checks++;
		assert (rx_count - start <= INSN_CREDITS) else begin
			$display("more than %0d records issued while credits were withheld", INSN_CREDITS);
			errors++;
		end
		hold_credits = 1'b0;
		wait_drain();
		show_result(5, "downstream back-pressure");

		// a stalled sink fills the FIFO, so the source has to run dry
		min_credits  = up_credits;
		hold_credits = 1'b1;
		repeat (16) add_insn(rand_op(), rand_opnd());
		repeat (40) @(posedge clk);
		hold_credits = 1'b0;
		wait_drain();
		checks++;
		assert (min_credits == 0) else begin
			$display("the byte source never ran out of credits");
			errors++;
		end
		checks++;
		assert (credit_pulses == bytes_sent) else begin
			$display("[ERROR] byte_credit total expected %h got %h", bytes_sent, credit_pulses);
			errors++;
		end
		show_result(6, "upstream credits");

		errors += dut0.chk0.fails;
		$display("6 tests, %0d checks, %0d records, %0d errors", checks, rx_count, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: src.f
source/insn_pkg.sv
source/byte_ingress.sv
source/insn_length_decode.sv
source/insn_assembler.sv
source/insn_egress.sv
source/insn_fetch_top.sv
verification/insn_fetch_chk.sv
verification/insn_fetch_tb.sv

// File: Bender.yml
package:
  name: insn_fetch

sources:
  - source/insn_pkg.sv
  - source/byte_ingress.sv
  - source/insn_length_decode.sv
  - source/insn_assembler.sv
  - source/insn_egress.sv
  - source/insn_fetch_top.sv
  - target: test
    files:
      - verification/insn_fetch_chk.sv
      - verification/insn_fetch_tb.sv
